// ==== Bender.yml ====
package:
  name: video_subsystem

sources:
  - rtl/video_pkg.sv
  - rtl/vram_sram.sv
  - rtl/vram_arbiter.sv
  - rtl/video_cpu_port.sv
  - rtl/video_line_fetch.sv
  - rtl/video_scanout.sv
  - rtl/video_top.sv
  - target: test
    files:
      - verif/video_checker.sv
      - verif/tb_video_top.sv

// ==== rtl/video_cpu_port.sv ====
`timescale 1ns/1ns

module video_cpu_port (
	input logic i_clock,
	input logic i_rst,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	output video_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_vram_request,
	output logic o_vram_rw,
	output video_pkg::addr_t o_vram_address,
	output video_pkg::data_t o_vram_wdata,
	input video_pkg::data_t i_vram_rdata,
	input logic i_vram_ready,

	output logic o_pal_we,
	output video_pkg::pal_index_t o_pal_index,
	output video_pkg::rgb_t o_pal_wdata,

	output video_pkg::addr_t o_read_offset,
	output video_pkg::data_t o_pitch,
	output video_pkg::skip_t o_skip
);
	import video_pkg::*;

	cpu_state_e state;
	logic [3:0] region;
	logic is_local;
	data_t local_rdata;

	assign region = i_cpu_address[23:20];
	assign is_local = (region == REGION_PALETTE) || (region == REGION_CONTROL);

	// Palette reads give zero.
	always_comb begin
		local_rdata = '0;
		if (region == REGION_CONTROL) begin
			case (i_cpu_address[3:2])
				REG_OFFSET: local_rdata = o_read_offset;
				REG_PITCH: local_rdata = o_pitch;
				REG_SKIP: local_rdata = data_t'(o_skip);
				default: local_rdata = '0;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= CPU_IDLE;
			o_cpu_ready <= 1'b0;
			o_vram_request <= 1'b0;
			o_pal_we <= 1'b0;
			o_read_offset <= '0;
			o_pitch <= '0;
			o_skip <= '0;
		end else begin
			o_cpu_ready <= 1'b0;
			o_pal_we <= 1'b0;
			unique case (state)
				CPU_IDLE: begin
					if (i_cpu_request && is_local) begin
						o_pal_we <= (region == REGION_PALETTE) && i_cpu_rw;
						state <= CPU_LOCAL;
					end else if (i_cpu_request) begin
						o_vram_request <= 1'b1;
						state <= CPU_VRAM_WAIT;
					end
				end
				CPU_VRAM_WAIT: begin
					if (i_vram_ready) begin
						o_vram_request <= 1'b0;
						o_cpu_ready <= 1'b1;
						state <= CPU_RELEASE;
					end
				end
				CPU_LOCAL: begin
					if (region == REGION_CONTROL && i_cpu_rw) begin
						case (i_cpu_address[3:2])
							REG_OFFSET: o_read_offset <= i_cpu_wdata;
							REG_PITCH: o_pitch <= i_cpu_wdata;
							REG_SKIP: o_skip <= i_cpu_wdata[1:0];
							default: ;
						endcase
					end
					o_cpu_ready <= 1'b1;
					state <= CPU_RELEASE;
				end
				CPU_RELEASE: begin
					// Wait for the CPU to drop its request.
					if (!i_cpu_request)
						state <= CPU_IDLE;
				end
				default: state <= CPU_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == CPU_IDLE && i_cpu_request) begin
			o_vram_rw <= i_cpu_rw;
			o_vram_address <= {8'h00, i_cpu_address[23:0]};
			o_vram_wdata <= i_cpu_wdata;
			o_pal_index <= i_cpu_address[9:2];
			o_pal_wdata <= i_cpu_wdata[23:0];
		end
		if (state == CPU_VRAM_WAIT && i_vram_ready)
			o_cpu_rdata <= i_vram_rdata;
		else if (state == CPU_LOCAL)
			o_cpu_rdata <= local_rdata;
	end

	// A VRAM response only answers a pending request.
	a_vram_response: assert property (@(posedge i_clock) disable iff (i_rst)
		i_vram_ready |-> state == CPU_VRAM_WAIT);

endmodule

// ==== rtl/video_line_fetch.sv ====
`timescale 1ns/1ns

module video_line_fetch #(
	parameter int MAX_PITCH = 640
)(
	input logic i_clock,
	input logic i_rst,
	input logic i_video_hblank,
	input logic i_video_vblank,
	input video_pkg::addr_t i_read_offset,
	input video_pkg::data_t i_pitch,
	input video_pkg::skip_t i_skip,

	output logic o_vram_request,
	output logic o_vram_rw,
	output video_pkg::addr_t o_vram_address,
	output video_pkg::data_t o_vram_wdata,
	input video_pkg::data_t i_vram_rdata,
	input logic i_vram_ready,

	output logic o_linebuf_we,
	output logic [$clog2(MAX_PITCH/4)-1:0] o_linebuf_index,
	output video_pkg::data_t o_linebuf_wdata
);
	import video_pkg::*;

	localparam int IW = $clog2(MAX_PITCH/4);

	fetch_state_e state;
	logic [1:0] hs;
	logic [1:0] vs;
	logic hblank_rise;
	logic vblank_rise;
	logic line_step;
	logic fetch_line;
	logic start_fetch;
	logic last_word;
	logic line_odd;
	addr_t row;
	logic [IW:0] column;
	data_t words;

	assign hblank_rise = hs[0] && !hs[1];
	assign vblank_rise = vs[0] && !vs[1];
	assign line_step = hblank_rise && !vblank_rise && !i_video_vblank;
	// Under line doubling only even lines fetch.
	assign fetch_line = !i_skip[1] || !line_odd;
	assign words = i_pitch >> 2;
	assign start_fetch = line_step && fetch_line && state == FETCH_IDLE && words != '0;
	assign last_word = (data_t'(column) + data_t'(1)) == words;

	// Read only.
	assign o_vram_rw = 1'b0;
	assign o_vram_wdata = '0;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= FETCH_IDLE;
			hs <= '0;
			vs <= '0;
			o_vram_request <= 1'b0;
			o_linebuf_we <= 1'b0;
			line_odd <= 1'b0;
			row <= '0;
			column <= '0;
		end else begin
			hs <= {hs[0], i_video_hblank};
			vs <= {vs[0], i_video_vblank};
			o_linebuf_we <= 1'b0;
			if (vblank_rise) begin
				row <= i_read_offset;
				line_odd <= 1'b0;
			end else if (line_step) begin
				if (fetch_line)
					row <= row + i_pitch;
				line_odd <= !line_odd;
			end
			unique case (state)
				FETCH_IDLE: begin
					if (start_fetch) begin
						column <= '0;
						state <= FETCH_REQUEST;
					end
				end
				FETCH_REQUEST: begin
					o_vram_request <= 1'b1;
					state <= FETCH_WAIT;
				end
				FETCH_WAIT: begin
					if (i_vram_ready) begin
						o_vram_request <= 1'b0;
						o_linebuf_we <= 1'b1;
						column <= column + 1'b1;
						state <= last_word ? FETCH_IDLE : FETCH_REQUEST;
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start_fetch)
			o_vram_address <= row;
		else if (state == FETCH_WAIT && i_vram_ready)
			o_vram_address <= o_vram_address + 32'd4;
		if (state == FETCH_WAIT && i_vram_ready) begin
			o_linebuf_index <= column[IW-1:0];
			o_linebuf_wdata <= i_vram_rdata;
		end
	end

	// Pitch from the CPU port must fit the line buffer.
	a_pitch_fits: assert property (@(posedge i_clock) disable iff (i_rst)
		state != FETCH_IDLE |-> words <= data_t'(MAX_PITCH/4));

endmodule

// ==== rtl/video_pkg.sv ====
package video_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [23:0] rgb_t;
	typedef logic [7:0] pal_index_t;
	typedef logic [10:0] coord_t;
	typedef logic [1:0] skip_t;

	// Address bits 23 to 20 select the region.
	localparam logic [3:0] REGION_PALETTE = 4'hE;
	localparam logic [3:0] REGION_CONTROL = 4'hF;

	// Control register word index, address bits 3 to 2.
	localparam logic [1:0] REG_OFFSET = 2'd0;
	localparam logic [1:0] REG_PITCH = 2'd1;
	localparam logic [1:0] REG_SKIP = 2'd2;

	typedef enum logic [1:0] {
		CPU_IDLE,
		CPU_VRAM_WAIT,
		CPU_LOCAL,
		CPU_RELEASE
	} cpu_state_e;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,
		FETCH_WAIT
	} fetch_state_e;

endpackage

// ==== rtl/video_scanout.sv ====
`timescale 1ns/1ns

module video_scanout #(
	parameter int MAX_PITCH = 640
)(
	input logic i_clock,
	input video_pkg::coord_t i_video_pos_x,
	input video_pkg::skip_t i_skip,

	input logic i_linebuf_we,
	input logic [$clog2(MAX_PITCH/4)-1:0] i_linebuf_index,
	input video_pkg::data_t i_linebuf_wdata,

	input logic i_pal_we,
	input video_pkg::pal_index_t i_pal_index,
	input video_pkg::rgb_t i_pal_wdata,

	output video_pkg::rgb_t o_video_rgb
);
	import video_pkg::*;

	localparam int LINE_WORDS = MAX_PITCH/4;
	localparam int IW = $clog2(LINE_WORDS);

	data_t line_ram [LINE_WORDS];
	rgb_t pal_ram [256];

	logic [IW-1:0] word_index;
	logic [1:0] byte_sel;
	logic [1:0] byte_sel_q;
	data_t line_word;
	pal_index_t pixel;

	//==========================================================================
	// Stage 1, beam position to word and byte.
	//==========================================================================

	always_ff @(posedge i_clock) begin
		if (i_skip[0]) begin
			word_index <= IW'(i_video_pos_x >> 3);
			byte_sel <= i_video_pos_x[2:1];
		end else begin
			word_index <= IW'(i_video_pos_x >> 2);
			byte_sel <= i_video_pos_x[1:0];
		end
	end

	// Stage 2, line buffer.
	always_ff @(posedge i_clock) begin
		if (i_linebuf_we)
			line_ram[i_linebuf_index] <= i_linebuf_wdata;
		line_word <= line_ram[word_index];
		byte_sel_q <= byte_sel;
	end

	// Lowest byte is the leftmost pixel.
	assign pixel = line_word[8*byte_sel_q +: 8];

	// Stage 3, palette.
	always_ff @(posedge i_clock) begin
		if (i_pal_we)
			pal_ram[i_pal_index] <= i_pal_wdata;
		o_video_rgb <= pal_ram[pixel];
	end

endmodule

// ==== rtl/video_top.sv ====
`timescale 1ns/1ns

module video_top #(
	parameter int MAX_PITCH = 640,
	parameter int VRAM_WORDS = 16384
)(
	input logic i_clock,
	input logic i_rst,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	output video_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,

	input logic i_video_hblank,
	input logic i_video_vblank,
	input video_pkg::coord_t i_video_pos_x,
	input video_pkg::coord_t i_video_pos_y,
	output video_pkg::rgb_t o_video_rgb
);
	import video_pkg::*;

	logic cpu_vram_request, cpu_vram_rw, cpu_vram_ready;
	addr_t cpu_vram_address;
	data_t cpu_vram_wdata, cpu_vram_rdata;

	logic fetch_vram_request, fetch_vram_rw, fetch_vram_ready;
	addr_t fetch_vram_address;
	data_t fetch_vram_wdata, fetch_vram_rdata;

	logic mem_request, mem_rw, mem_ready;
	addr_t mem_address;
	data_t mem_wdata, mem_rdata;

	logic pal_we;
	pal_index_t pal_index;
	rgb_t pal_wdata;
	addr_t read_offset;
	data_t pitch;
	skip_t skip;

	logic linebuf_we;
	logic [$clog2(MAX_PITCH/4)-1:0] linebuf_index;
	data_t linebuf_wdata;

	video_cpu_port cpu_port_i (
		.i_clock, .i_rst,
		.i_cpu_request, .i_cpu_rw, .i_cpu_address, .i_cpu_wdata, .o_cpu_rdata, .o_cpu_ready,
		.o_vram_request(cpu_vram_request), .o_vram_rw(cpu_vram_rw),
		.o_vram_address(cpu_vram_address), .o_vram_wdata(cpu_vram_wdata),
		.i_vram_rdata(cpu_vram_rdata), .i_vram_ready(cpu_vram_ready),
		.o_pal_we(pal_we), .o_pal_index(pal_index), .o_pal_wdata(pal_wdata),
		.o_read_offset(read_offset), .o_pitch(pitch), .o_skip(skip)
	);

	video_line_fetch #(.MAX_PITCH(MAX_PITCH)) line_fetch_i (
		.i_clock, .i_rst, .i_video_hblank, .i_video_vblank,
		.i_read_offset(read_offset), .i_pitch(pitch), .i_skip(skip),
		.o_vram_request(fetch_vram_request), .o_vram_rw(fetch_vram_rw),
		.o_vram_address(fetch_vram_address), .o_vram_wdata(fetch_vram_wdata),
		.i_vram_rdata(fetch_vram_rdata), .i_vram_ready(fetch_vram_ready),
		.o_linebuf_we(linebuf_we), .o_linebuf_index(linebuf_index),
		.o_linebuf_wdata(linebuf_wdata)
	);

	vram_arbiter arbiter_i (
		.i_clock, .i_rst,
		.i_fetch_request(fetch_vram_request), .i_fetch_rw(fetch_vram_rw),
		.i_fetch_address(fetch_vram_address), .i_fetch_wdata(fetch_vram_wdata),
		.o_fetch_rdata(fetch_vram_rdata), .o_fetch_ready(fetch_vram_ready),
		.i_cpu_request(cpu_vram_request), .i_cpu_rw(cpu_vram_rw),
		.i_cpu_address(cpu_vram_address), .i_cpu_wdata(cpu_vram_wdata),
		.o_cpu_rdata(cpu_vram_rdata), .o_cpu_ready(cpu_vram_ready),
		.o_mem_request(mem_request), .o_mem_rw(mem_rw), .o_mem_address(mem_address),
		.o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata), .i_mem_ready(mem_ready)
	);

	vram_sram #(.VRAM_WORDS(VRAM_WORDS)) vram_i (
		.i_clock, .i_rst,
		.i_request(mem_request), .i_rw(mem_rw), .i_address(mem_address),
		.i_wdata(mem_wdata), .o_rdata(mem_rdata), .o_ready(mem_ready)
	);

	video_scanout #(.MAX_PITCH(MAX_PITCH)) scanout_i (
		.i_clock, .i_video_pos_x, .i_skip(skip),
		.i_linebuf_we(linebuf_we), .i_linebuf_index(linebuf_index),
		.i_linebuf_wdata(linebuf_wdata),
		.i_pal_we(pal_we), .i_pal_index(pal_index), .i_pal_wdata(pal_wdata),
		.o_video_rgb
	);

endmodule

// ==== rtl/vram_arbiter.sv ====
`timescale 1ns/1ns

module vram_arbiter (
	input logic i_clock,
	input logic i_rst,

	input logic i_fetch_request,
	input logic i_fetch_rw,
	input video_pkg::addr_t i_fetch_address,
	input video_pkg::data_t i_fetch_wdata,
	output video_pkg::data_t o_fetch_rdata,
	output logic o_fetch_ready,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	output video_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_mem_request,
	output logic o_mem_rw,
	output video_pkg::addr_t o_mem_address,
	output video_pkg::data_t o_mem_wdata,
	input video_pkg::data_t i_mem_rdata,
	input logic i_mem_ready
);
	logic busy;
	logic owner_fetch;
	logic grant_fetch;
	logic grant_cpu;

	// Fetcher wins when both ask.
	assign grant_fetch = !busy && i_fetch_request;
	assign grant_cpu = !busy && !i_fetch_request && i_cpu_request;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy <= 1'b0;
			owner_fetch <= 1'b0;
			o_mem_request <= 1'b0;
		end else begin
			o_mem_request <= grant_fetch || grant_cpu;
			if (grant_fetch || grant_cpu) begin
				busy <= 1'b1;
				owner_fetch <= grant_fetch;
			end else if (i_mem_ready) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (grant_fetch) begin
			o_mem_rw <= i_fetch_rw;
			o_mem_address <= i_fetch_address;
			o_mem_wdata <= i_fetch_wdata;
		end else if (grant_cpu) begin
			o_mem_rw <= i_cpu_rw;
			o_mem_address <= i_cpu_address;
			o_mem_wdata <= i_cpu_wdata;
		end
	end

	//==========================================================================
	// Response routing.
	//==========================================================================

	assign o_fetch_ready = i_mem_ready && busy && owner_fetch;
	assign o_cpu_ready = i_mem_ready && busy && !owner_fetch;
	assign o_fetch_rdata = owner_fetch ? i_mem_rdata : '0;
	assign o_cpu_rdata = owner_fetch ? '0 : i_mem_rdata;

	// One grant at a time: each pulse is answered before another issues.
	a_single_grant: assert property (@(posedge i_clock) disable iff (i_rst)
		o_mem_request |=> i_mem_ready && !o_mem_request);

endmodule

// ==== rtl/vram_sram.sv ====
`timescale 1ns/1ns

module vram_sram #(
	parameter int VRAM_WORDS = 16384
)(
	input logic i_clock,
	input logic i_rst,
	input logic i_request,
	input logic i_rw,
	input video_pkg::addr_t i_address,
	input video_pkg::data_t i_wdata,
	output video_pkg::data_t o_rdata,
	output logic o_ready
);
	import video_pkg::*;

	localparam int AW = $clog2(VRAM_WORDS);

	data_t mem [VRAM_WORDS];
	logic [AW-1:0] word_index;

	// Word addressed, byte offset dropped.
	assign word_index = i_address[AW+1:2];

	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_ready <= 1'b0;
		else
			o_ready <= i_request;
	end

	always_ff @(posedge i_clock) begin
		if (i_request) begin
			if (i_rw)
				mem[word_index] <= i_wdata;
			o_rdata <= mem[word_index];
		end
	end

	// The arbiter waits for each response before the next request.
	a_no_overlap: assert property (@(posedge i_clock) disable iff (i_rst)
		i_request |-> !o_ready);

endmodule

// ==== sim.f ====
rtl/video_pkg.sv
rtl/vram_sram.sv
rtl/vram_arbiter.sv
rtl/video_cpu_port.sv
rtl/video_line_fetch.sv
rtl/video_scanout.sv
rtl/video_top.sv
verif/video_checker.sv
verif/tb_video_top.sv

// ==== verif/tb_video_top.sv ====
`timescale 1ns/1ns

module tb_video_top;
	import video_pkg::*;

	localparam int MAX_PITCH = 64;
	localparam int VRAM_WORDS = 1024;
	localparam int PITCH = 64;
	localparam int LINES = 6;
	localparam int HB = 100;
	localparam int VB = 10;
	localparam int FRAMES = 7;
	localparam int FRAME_CYCLES = VB + LINES * (HB + 2 * PITCH) + HB;
	localparam int CPU_OPS = 600;
	localparam int WATCHDOG_NS = (FRAMES * FRAME_CYCLES + CPU_OPS * 12 + 2000) * 40;

	logic i_clock = 1'b0;
	logic i_rst;
	logic i_cpu_request;
	logic i_cpu_rw;
	addr_t i_cpu_address;
	data_t i_cpu_wdata;
	data_t o_cpu_rdata;
	logic o_cpu_ready;
	logic i_video_hblank;
	logic i_video_vblank;
	coord_t i_video_pos_x;
	coord_t i_video_pos_y;
	rgb_t o_video_rgb;

	int chk_errors;
	int tb_errors = 0;
	int tests = 0;
	int passed = 0;
	int mark;
	addr_t t1_addr [32];
	addr_t reg_addr;
	int written [$];

	video_top #(.MAX_PITCH(MAX_PITCH), .VRAM_WORDS(VRAM_WORDS)) dut_i (.*);

	video_checker #(.VRAM_WORDS(VRAM_WORDS)) chk_i (
		.i_clock, .i_rst, .i_cpu_request, .i_cpu_rw, .i_cpu_address, .i_cpu_wdata,
		.i_cpu_rdata(o_cpu_rdata), .i_cpu_ready(o_cpu_ready),
		.i_video_hblank, .i_video_vblank, .i_video_pos_x,
		.i_video_rgb(o_video_rgb), .o_errors(chk_errors)
	);

	always #20 i_clock = !i_clock;

	task automatic step();
		@(posedge i_clock);
		#2;
	endtask

	task automatic cpu_access(input logic rw, input addr_t addr, input data_t wdata);
		int waited;
		waited = 0;
		i_cpu_request = 1'b1;
		i_cpu_rw = rw;
		i_cpu_address = addr;
		i_cpu_wdata = wdata;
		@(posedge i_clock);
		while (!o_cpu_ready && waited < 200) begin
			waited++;
			@(posedge i_clock);
		end
		if (!o_cpu_ready) begin
			$display("CPU access to %h never got a ready pulse", addr);
			tb_errors++;
		end
		#2;
		i_cpu_request = 1'b0;
		step();
	endtask

	// Vblank, then lines of hblank and active pixels.
	task automatic run_frame(input int width);
		i_video_vblank = 1'b1;
		i_video_hblank = 1'b0;
		repeat (VB) step();
		i_video_vblank = 1'b0;
		for (int l = 0; l < LINES; l++) begin
			i_video_pos_y = coord_t'(l);
			i_video_hblank = 1'b1;
			repeat (HB) step();
			i_video_hblank = 1'b0;
			for (int x = 0; x < width; x++) begin
				i_video_pos_x = coord_t'(x);
				step();
			end
		end
		i_video_hblank = 1'b1;
		repeat (HB) step();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (chk_errors + tb_errors == mark) begin
			passed++;
			$display("%s: PASS", name);
		end else begin
			$display("%s: FAIL", name);
		end
		mark = chk_errors + tb_errors;
	endtask

	task automatic background_traffic();
		int idx;
		repeat (40) begin
			repeat ($urandom % 20) step();
			if (written.size() > 0 && $urandom % 2) begin
				idx = written[$urandom % written.size()];
				cpu_access(1'b0, addr_t'(idx) << 2, '0);
			end else begin
				idx = 512 + $urandom % 512;
				written.push_back(idx);
				cpu_access(1'b1, addr_t'(idx) << 2, $urandom);
			end
		end
	endtask

	//==========================================================================
	// Test sequence.
	//==========================================================================

	initial begin
		void'($urandom(42));
		i_rst = 1'b1;
		i_cpu_request = 1'b0;
		i_cpu_rw = 1'b0;
		i_cpu_address = '0;
		i_cpu_wdata = '0;
		i_video_hblank = 1'b1;
		i_video_vblank = 1'b0;
		i_video_pos_x = '0;
		i_video_pos_y = '0;
		repeat (3) @(posedge i_clock);
		#2;
		i_rst = 1'b0;
		step();
		mark = 0;

		foreach (t1_addr[i]) begin
			t1_addr[i] = addr_t'($urandom % VRAM_WORDS) << 2;
			cpu_access(1'b1, t1_addr[i], $urandom);
		end
		foreach (t1_addr[i])
			cpu_access(1'b0, t1_addr[i], '0);
		end_test("vram write and read back");

		repeat (8) begin
			reg_addr = 32'h00F0_0000 | (($urandom % 4) << 2);
			cpu_access(1'b1, reg_addr, $urandom);
			cpu_access(1'b0, reg_addr, '0);
			cpu_access(1'b0, 32'h00E0_0000 | (($urandom % 256) << 2), '0);
		end
		end_test("register and palette reads");

		cpu_access(1'b1, 32'h00F0_0000, 32'd0);
		cpu_access(1'b1, 32'h00F0_0004, PITCH);
		cpu_access(1'b1, 32'h00F0_0008, 32'd0);
		for (int i = 0; i < 256; i++)
			cpu_access(1'b1, 32'h00E0_0000 | (i << 2), $urandom);
		for (int i = 0; i < 128; i++)
			cpu_access(1'b1, addr_t'(i) << 2, $urandom);
		repeat (2) run_frame(PITCH);
		end_test("frames without skip");

		cpu_access(1'b1, 32'h00F0_0008, 32'd1);
		run_frame(2 * PITCH);
		end_test("pixel doubling");

		cpu_access(1'b1, 32'h00F0_0000, 32'd256);
		cpu_access(1'b1, 32'h00F0_0008, 32'd2);
		repeat (2) run_frame(PITCH);
		end_test("line doubling with offset");

		cpu_access(1'b1, 32'h00F0_0000, 32'd0);
		cpu_access(1'b1, 32'h00F0_0008, 32'd0);
		fork
			repeat (2) run_frame(PITCH);
			background_traffic();
		join
		end_test("cpu traffic during fetch");

		$display("%0d tests, %0d passed, %0d errors", tests, passed, chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Simulation ran out of time before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verif/video_checker.sv ====
`timescale 1ns/1ns

module video_checker #(
	parameter int VRAM_WORDS = 1024
)(
	input logic i_clock,
	input logic i_rst,
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	input video_pkg::data_t i_cpu_rdata,
	input logic i_cpu_ready,
	input logic i_video_hblank,
	input logic i_video_vblank,
	input video_pkg::coord_t i_video_pos_x,
	input video_pkg::rgb_t i_video_rgb,
	output int o_errors
);
	import video_pkg::*;

	data_t vram_m [VRAM_WORDS];
	rgb_t pal_m [256];
	addr_t offset_m;
	data_t pitch_m;
	skip_t skip_m;

	logic hb_q;
	logic vb_q;
	int line_cnt;
	logic exp_valid [3];
	rgb_t exp_rgb [3];
	int exp_x [3];
	int exp_line [3];

	function automatic int vram_word(input addr_t a);
		return int'((a[23:0] >> 2) % VRAM_WORDS);
	endfunction

	function automatic data_t predict_read(input addr_t a);
		if (a[23:20] == REGION_PALETTE)
			return '0;
		if (a[23:20] == REGION_CONTROL) begin
			case (a[3:2])
				REG_OFFSET: return offset_m;
				REG_PITCH: return pitch_m;
				REG_SKIP: return {30'd0, skip_m};
				default: return '0;
			endcase
		end
		return vram_m[vram_word(a)];
	endfunction

	task automatic apply_write(input addr_t a, input data_t d);
		if (a[23:20] == REGION_PALETTE) begin
			pal_m[a[9:2]] = d[23:0];
		end else if (a[23:20] == REGION_CONTROL) begin
			case (a[3:2])
				REG_OFFSET: offset_m = d;
				REG_PITCH: pitch_m = d;
				REG_SKIP: skip_m = d[1:0];
				default: ;
			endcase
		end else begin
			vram_m[vram_word(a)] = d;
		end
	endtask

	// Byte address is row start plus pixel index. Lowest byte is leftmost.
	function automatic rgb_t predict_pixel(input int line, input int x);
		int row;
		int idx;
		addr_t a;
		data_t w;
		row = skip_m[1] ? line / 2 : line;
		idx = skip_m[0] ? x / 2 : x;
		a = offset_m + addr_t'(row) * pitch_m + addr_t'(idx);
		w = vram_m[vram_word(a)];
		return pal_m[w[8*a[1:0] +: 8]];
	endfunction

	//==========================================================================
	// Sampled at each rising edge before the DUT's registers update.
	//==========================================================================

	always @(posedge i_clock) begin
		if (i_rst) begin
			offset_m = '0;
			pitch_m = '0;
			skip_m = '0;
			hb_q = 1'b0;
			vb_q = 1'b0;
			line_cnt = 0;
			for (int i = 0; i < 3; i++)
				exp_valid[i] = 1'b0;
		end else begin
			if (i_cpu_ready && !i_cpu_request) begin
				$display("CPU ready pulse came with no request pending at %0t", $time);
				o_errors++;
			end
			if (i_cpu_ready && i_cpu_rw) begin
				apply_write(i_cpu_address, i_cpu_wdata);
			end else if (i_cpu_ready && i_cpu_rdata !== predict_read(i_cpu_address)) begin
				$display("FAILED at %0t: read of %h gave %h, expected %h", $time,
					i_cpu_address, i_cpu_rdata, predict_read(i_cpu_address));
				o_errors++;
			end
			if (exp_valid[2] && i_video_rgb !== exp_rgb[2]) begin
				$display("FAILED at %0t: pixel x=%0d line=%0d gave %h, expected %h",
					$time, exp_x[2], exp_line[2], i_video_rgb, exp_rgb[2]);
				o_errors++;
			end
			for (int i = 2; i > 0; i--) begin
				exp_valid[i] = exp_valid[i-1];
				exp_rgb[i] = exp_rgb[i-1];
				exp_x[i] = exp_x[i-1];
				exp_line[i] = exp_line[i-1];
			end
			exp_valid[0] = !i_video_hblank && !i_video_vblank && line_cnt > 0;
			exp_x[0] = int'(i_video_pos_x);
			exp_line[0] = line_cnt - 1;
			if (exp_valid[0])
				exp_rgb[0] = predict_pixel(exp_line[0], exp_x[0]);
			// Lines counted from the rising edge of vblank.
			if (i_video_vblank && !vb_q)
				line_cnt = 0;
			else if (i_video_hblank && !hb_q && !i_video_vblank)
				line_cnt++;
			hb_q = i_video_hblank;
			vb_q = i_video_vblank;
		end
	end

	initial o_errors = 0;

endmodule
